/* logic/msgq_pkg.sv */
`default_nettype none

package msgq_pkg;

	typedef logic [31:0] word_t;

	// One processor access, valid for a single cycle.
	typedef struct packed {
		logic        rd;
		logic        wr;
		logic [15:0] addr;
		word_t       wdata;
	} bus_req_t;

	typedef struct packed {
		logic  rd_valid;
		word_t rdata;
	} bus_rsp_t;

	// Bit 0 is the inbound side, bit 1 the outbound side.
	typedef struct packed {
		logic out_irq_en;
		logic in_irq_en;
	} ctrl_t;

	typedef struct packed {
		logic out_irq;
		logic in_irq;
	} status_t;

	typedef enum logic [2:0] {
		REG_IN_RD_PTR  = 3'd0,
		REG_IN_WR_PTR  = 3'd1,
		REG_OUT_RD_PTR = 3'd2,
		REG_OUT_WR_PTR = 3'd3,
		REG_CTRL       = 3'd4,
		REG_STATUS     = 3'd5
	} reg_idx_e;

	// First word of ring memory in the processor map.
	localparam logic [15:0] RING_BASE = 16'h0400;

endpackage

`default_nettype wire

/* logic/msgq_ring_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module msgq_ring_ram #(
	parameter int DEPTH_BITS = 4
) (
	input  wire                   clk,
	input  wire                   a_wr,
	input  wire                   a_rd,
	input  wire [DEPTH_BITS-1:0]  a_addr,
	input  msgq_pkg::word_t       a_wdata,
	output msgq_pkg::word_t       a_rdata,
	input  wire                   b_wr,
	input  wire                   b_rd,
	input  wire [DEPTH_BITS-1:0]  b_addr,
	input  msgq_pkg::word_t       b_wdata,
	output msgq_pkg::word_t       b_rdata
);

	msgq_pkg::word_t mem [1 << DEPTH_BITS];

	// Read outputs hold their last value between reads.
	always_ff @(posedge clk) begin
		if (a_wr)
			mem[a_addr] <= a_wdata;
		if (b_wr)
			mem[b_addr] <= b_wdata;
		if (a_rd)
			a_rdata <= mem[a_addr];
		if (b_rd)
			b_rdata <= mem[b_addr];
	end

	assert property (@(posedge clk) !(a_wr && b_wr && (a_addr == b_addr)));

endmodule

`default_nettype wire

/* logic/msgq_bus_port.sv */
`timescale 1ns/1ps
`default_nettype none

module msgq_bus_port #(
	parameter int DEPTH_BITS = 4
) (
	input  wire                       clk,
	input  wire                       arst_n,
	input  msgq_pkg::bus_req_t        req,
	output msgq_pkg::bus_rsp_t        rsp,
	output logic                      reg_wr,
	output msgq_pkg::reg_idx_e        reg_idx,
	output msgq_pkg::word_t           reg_wdata,
	input  msgq_pkg::word_t           reg_rdata,
	output logic                      in_ram_rd,
	output logic [DEPTH_BITS-1:0]     in_ram_addr,
	input  msgq_pkg::word_t           in_ram_rdata,
	output logic                      out_ram_wr,
	output logic                      out_ram_rd,
	output logic [DEPTH_BITS-1:0]     out_ram_addr,
	output msgq_pkg::word_t           out_ram_wdata,
	input  msgq_pkg::word_t           out_ram_rdata
);

	localparam int DEPTH = 1 << DEPTH_BITS;

	typedef enum logic [1:0] {
		SRC_ZERO,
		SRC_REG,
		SRC_IN,
		SRC_OUT
	} src_e;

	logic            reg_space;
	logic            reg_hit;
	logic            in_hit;
	logic            out_hit;
	logic [15:0]     ring_off;
	src_e            src_q;
	logic            rd_valid_q;
	msgq_pkg::word_t reg_q;

	// Ring space starts at RING_BASE, inbound half first.
	assign reg_space = req.addr < msgq_pkg::RING_BASE;
	assign ring_off  = req.addr - msgq_pkg::RING_BASE;
	assign reg_hit   = reg_space && (req.addr < 16'd6);
	assign in_hit    = !reg_space && (ring_off < DEPTH);
	assign out_hit   = !reg_space && (ring_off >= DEPTH) && (ring_off < 2 * DEPTH);

	assign reg_wr    = req.wr && reg_hit;
	assign reg_idx   = msgq_pkg::reg_idx_e'(req.addr[2:0]);
	assign reg_wdata = req.wdata;

	// The inbound ring is read-only from the bus.
	assign in_ram_rd     = req.rd && in_hit;
	assign in_ram_addr   = ring_off[DEPTH_BITS-1:0];
	assign out_ram_wr    = req.wr && out_hit;
	assign out_ram_rd    = req.rd && out_hit;
	assign out_ram_addr  = ring_off[DEPTH_BITS-1:0];
	assign out_ram_wdata = req.wdata;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid_q <= 1'b0;
			src_q      <= SRC_ZERO;
		end else begin
			rd_valid_q <= req.rd;
			if (req.rd) begin
				if (reg_hit)
					src_q <= SRC_REG;
				else if (in_hit)
					src_q <= SRC_IN;
				else if (out_hit)
					src_q <= SRC_OUT;
				else
					src_q <= SRC_ZERO;
			end
		end
	end

	// Register value is sampled here; ring data comes from the RAM output.
	always_ff @(posedge clk) begin
		if (req.rd)
			reg_q <= reg_rdata;
	end

	always_comb begin
		rsp.rd_valid = rd_valid_q;
		case (src_q)
			SRC_REG: rsp.rdata = reg_q;
			SRC_IN:  rsp.rdata = in_ram_rdata;
			SRC_OUT: rsp.rdata = out_ram_rdata;
			default: rsp.rdata = '0;
		endcase
	end

	assert property (@(posedge clk) disable iff (!arst_n) !(req.rd && req.wr));

endmodule

`default_nettype wire

/* logic/msgq_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module msgq_regs #(
	parameter int DEPTH_BITS = 4
) (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire                       reg_wr,
	input  msgq_pkg::reg_idx_e        reg_idx,
	input  msgq_pkg::word_t           reg_wdata,
	output msgq_pkg::word_t           reg_rdata,
	input  wire                       in_push,
	output logic [DEPTH_BITS-1:0]     in_wr_ptr,
	output logic                      in_full,
	input  wire                       out_pop,
	output logic [DEPTH_BITS-1:0]     out_rd_ptr,
	output logic                      out_empty,
	output logic                      irq
);

	logic [DEPTH_BITS-1:0] in_rd_ptr;
	logic [DEPTH_BITS-1:0] out_wr_ptr;
	logic [DEPTH_BITS-1:0] in_wr_next;
	logic                  in_empty;
	msgq_pkg::ctrl_t       ctrl;
	msgq_pkg::status_t     status;

	// One slot stays free, so full is write pointer plus one.
	assign in_wr_next = in_wr_ptr + 1'b1;
	assign in_full    = (in_wr_next == in_rd_ptr);
	assign in_empty   = (in_wr_ptr == in_rd_ptr);
	assign out_empty  = (out_rd_ptr == out_wr_ptr);

	assign status.in_irq  = !in_empty;
	assign status.out_irq = out_empty;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			in_rd_ptr  <= '0;
			in_wr_ptr  <= '0;
			out_rd_ptr <= '0;
			out_wr_ptr <= '0;
			ctrl       <= '0;
			irq        <= 1'b0;
		end else begin
			if (reg_wr) begin
				case (reg_idx)
					msgq_pkg::REG_IN_RD_PTR:  in_rd_ptr  <= reg_wdata[DEPTH_BITS-1:0];
					msgq_pkg::REG_OUT_WR_PTR: out_wr_ptr <= reg_wdata[DEPTH_BITS-1:0];
					msgq_pkg::REG_CTRL:       ctrl       <= msgq_pkg::ctrl_t'(reg_wdata[1:0]);
					default: ;
				endcase
			end
			// Stream-side pointers move only on their strobes.
			if (in_push)
				in_wr_ptr <= in_wr_ptr + 1'b1;
			if (out_pop)
				out_rd_ptr <= out_rd_ptr + 1'b1;
			irq <= |(status & ctrl);
		end
	end

	always_comb begin
		reg_rdata = '0;
		case (reg_idx)
			msgq_pkg::REG_IN_RD_PTR:  reg_rdata[DEPTH_BITS-1:0] = in_rd_ptr;
			msgq_pkg::REG_IN_WR_PTR:  reg_rdata[DEPTH_BITS-1:0] = in_wr_ptr;
			msgq_pkg::REG_OUT_RD_PTR: reg_rdata[DEPTH_BITS-1:0] = out_rd_ptr;
			msgq_pkg::REG_OUT_WR_PTR: reg_rdata[DEPTH_BITS-1:0] = out_wr_ptr;
			msgq_pkg::REG_CTRL:       reg_rdata[1:0] = ctrl;
			msgq_pkg::REG_STATUS:     reg_rdata[1:0] = status;
			default: ;
		endcase
	end

	assert property (@(posedge clk) disable iff (!arst_n) in_push |-> !in_full);

endmodule

`default_nettype wire

/* logic/msgq_stream_in.sv */
`timescale 1ns/1ps
`default_nettype none

module msgq_stream_in #(
	parameter int DEPTH_BITS = 4
) (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire                       in_valid,
	input  msgq_pkg::word_t           in_data,
	output logic                      in_ready,
	input  wire                       in_full,
	input  wire [DEPTH_BITS-1:0]      in_wr_ptr,
	output logic                      in_push,
	output logic                      ram_wr,
	output logic [DEPTH_BITS-1:0]     ram_addr,
	output msgq_pkg::word_t           ram_wdata
);

	logic accept;

	assign in_ready = !in_full;
	assign accept   = in_valid && in_ready;

	// Word lands in the ring on the same edge the pointer moves.
	assign ram_wr    = accept;
	assign ram_addr  = in_wr_ptr;
	assign ram_wdata = in_data;
	assign in_push   = accept;

	// A stalled source keeps its word until the ring takes it.
	assert property (@(posedge clk) disable iff (!arst_n)
		in_valid && !in_ready |=> in_valid && $stable(in_data));

endmodule

`default_nettype wire

/* logic/msgq_stream_out.sv */
`timescale 1ns/1ps
`default_nettype none

module msgq_stream_out #(
	parameter int DEPTH_BITS = 4
) (
	input  wire                       clk,
	input  wire                       arst_n,
	input  wire                       out_empty,
	input  wire [DEPTH_BITS-1:0]      out_rd_ptr,
	output logic                      out_pop,
	output logic                      ram_rd,
	output logic [DEPTH_BITS-1:0]     ram_addr,
	input  msgq_pkg::word_t           ram_rdata,
	output logic                      out_valid,
	output msgq_pkg::word_t           out_data,
	input  wire                       out_ready
);

	logic            out_v;
	logic            skid_v;
	logic            pend;
	msgq_pkg::word_t out_q;
	msgq_pkg::word_t skid_q;
	logic [1:0]      cnt;
	logic            take;
	logic            fetch;
	logic            load_out;
	logic            load_skid;
	logic            shift_skid;

	// Word order is output register, then skid, then the RAM read in flight.
	assign out_valid = out_v || pend;
	assign out_data  = out_v ? out_q : ram_rdata;
	assign take      = out_valid && out_ready;

	// Words held or in flight never exceed the two holding slots.
	assign cnt   = {1'b0, out_v} + {1'b0, skid_v} + {1'b0, pend};
	assign fetch = !out_empty && ((cnt < 2'd2) || take);

	assign ram_rd   = fetch;
	assign ram_addr = out_rd_ptr;
	assign out_pop  = fetch;

	assign shift_skid = take && skid_v;
	assign load_out   = pend && (take ? out_v : !out_v);
	assign load_skid  = pend && !take && out_v;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			out_v  <= 1'b0;
			skid_v <= 1'b0;
			pend   <= 1'b0;
		end else begin
			pend <= fetch;
			if (load_out)
				out_v <= 1'b1;
			else if (take && !skid_v)
				out_v <= 1'b0;
			if (shift_skid)
				skid_v <= 1'b0;
			else if (load_skid)
				skid_v <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (shift_skid)
			out_q <= skid_q;
		else if (load_out)
			out_q <= ram_rdata;
		if (load_skid)
			skid_q <= ram_rdata;
	end

	assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data));

endmodule

`default_nettype wire

/* logic/msgq_top.sv */
`timescale 1ns/1ps
`default_nettype none

module msgq_top #(
	parameter int DEPTH_BITS = 4
) (
	input  wire                 clk,
	input  wire                 arst_n,
	input  msgq_pkg::bus_req_t  bus_req,
	output msgq_pkg::bus_rsp_t  bus_rsp,
	input  wire                 in_valid,
	input  msgq_pkg::word_t     in_data,
	output logic                in_ready,
	output logic                out_valid,
	output msgq_pkg::word_t     out_data,
	input  wire                 out_ready,
	output logic                irq
);

	logic                  reg_wr;
	msgq_pkg::reg_idx_e    reg_idx;
	msgq_pkg::word_t       reg_wdata;
	msgq_pkg::word_t       reg_rdata;
	logic                  in_ram_rd;
	logic [DEPTH_BITS-1:0] in_ram_addr;
	msgq_pkg::word_t       in_ram_rdata;
	logic                  out_ram_wr;
	logic                  out_ram_rd;
	logic [DEPTH_BITS-1:0] out_ram_addr;
	msgq_pkg::word_t       out_ram_wdata;
	msgq_pkg::word_t       out_ram_rdata;
	logic                  in_push;
	logic [DEPTH_BITS-1:0] in_wr_ptr;
	logic                  in_full;
	logic                  out_pop;
	logic [DEPTH_BITS-1:0] out_rd_ptr;
	logic                  out_empty;
	logic                  in_wr;
	logic [DEPTH_BITS-1:0] in_wr_addr;
	msgq_pkg::word_t       in_wr_data;
	logic                  out_fetch;
	logic [DEPTH_BITS-1:0] out_fetch_addr;
	msgq_pkg::word_t       out_fetch_data;

	msgq_bus_port #(.DEPTH_BITS(DEPTH_BITS)) msgq_bus_port_inst (
		.clk           (clk),
		.arst_n        (arst_n),
		.req           (bus_req),
		.rsp           (bus_rsp),
		.reg_wr        (reg_wr),
		.reg_idx       (reg_idx),
		.reg_wdata     (reg_wdata),
		.reg_rdata     (reg_rdata),
		.in_ram_rd     (in_ram_rd),
		.in_ram_addr   (in_ram_addr),
		.in_ram_rdata  (in_ram_rdata),
		.out_ram_wr    (out_ram_wr),
		.out_ram_rd    (out_ram_rd),
		.out_ram_addr  (out_ram_addr),
		.out_ram_wdata (out_ram_wdata),
		.out_ram_rdata (out_ram_rdata)
	);

	msgq_regs #(.DEPTH_BITS(DEPTH_BITS)) msgq_regs_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.reg_wr     (reg_wr),
		.reg_idx    (reg_idx),
		.reg_wdata  (reg_wdata),
		.reg_rdata  (reg_rdata),
		.in_push    (in_push),
		.in_wr_ptr  (in_wr_ptr),
		.in_full    (in_full),
		.out_pop    (out_pop),
		.out_rd_ptr (out_rd_ptr),
		.out_empty  (out_empty),
		.irq        (irq)
	);

	// Inbound ring: bus reads on port A, stream writes on port B.
	msgq_ring_ram #(.DEPTH_BITS(DEPTH_BITS)) in_ram_inst (
		.clk     (clk),
		.a_wr    (1'b0),
		.a_rd    (in_ram_rd),
		.a_addr  (in_ram_addr),
		.a_wdata ('0),
		.a_rdata (in_ram_rdata),
		.b_wr    (in_wr),
		.b_rd    (1'b0),
		.b_addr  (in_wr_addr),
		.b_wdata (in_wr_data),
		.b_rdata ()
	);

	// Outbound ring: bus fills port A, stream fetches from port B.
	msgq_ring_ram #(.DEPTH_BITS(DEPTH_BITS)) out_ram_inst (
		.clk     (clk),
		.a_wr    (out_ram_wr),
		.a_rd    (out_ram_rd),
		.a_addr  (out_ram_addr),
		.a_wdata (out_ram_wdata),
		.a_rdata (out_ram_rdata),
		.b_wr    (1'b0),
		.b_rd    (out_fetch),
		.b_addr  (out_fetch_addr),
		.b_wdata ('0),
		.b_rdata (out_fetch_data)
	);

	msgq_stream_in #(.DEPTH_BITS(DEPTH_BITS)) msgq_stream_in_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.in_full   (in_full),
		.in_wr_ptr (in_wr_ptr),
		.in_push   (in_push),
		.ram_wr    (in_wr),
		.ram_addr  (in_wr_addr),
		.ram_wdata (in_wr_data)
	);

	msgq_stream_out #(.DEPTH_BITS(DEPTH_BITS)) msgq_stream_out_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.out_empty  (out_empty),
		.out_rd_ptr (out_rd_ptr),
		.out_pop    (out_pop),
		.ram_rd     (out_fetch),
		.ram_addr   (out_fetch_addr),
		.ram_rdata  (out_fetch_data),
		.out_valid  (out_valid),
		.out_data   (out_data),
		.out_ready  (out_ready)
	);

endmodule

`default_nettype wire

/* test/msgq_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module msgq_clock #(
	parameter int PERIOD_NS = 10
) (
	output logic clk
);

	initial clk = 1'b0;

	always #(PERIOD_NS / 2) clk = ~clk;

endmodule

`default_nettype wire

/* test/msgq_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module msgq_tb;

	localparam int DEPTH_BITS = 4;
	localparam int MAX_CASES  = 64;

	logic               clk;
	logic               arst_n;
	msgq_pkg::bus_req_t bus_req;
	msgq_pkg::bus_rsp_t bus_rsp;
	logic               in_valid;
	msgq_pkg::word_t    in_data;
	logic               in_ready;
	logic               out_valid;
	msgq_pkg::word_t    out_data;
	logic               out_ready;
	logic               irq;

	// Each entry is op, count or address, then a data word.
	logic [51:0]        cases [MAX_CASES];
	logic [15:0]        lfsr;
	int                 case_count;
	int                 cycles = 0;
	int                 limit = 100000;

	msgq_clock #(.PERIOD_NS(10)) msgq_clock_inst (.clk(clk));

	msgq_top #(.DEPTH_BITS(DEPTH_BITS)) msgq_top_inst (
		.clk       (clk),
		.arst_n    (arst_n),
		.bus_req   (bus_req),
		.bus_rsp   (bus_rsp),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready),
		.irq       (irq)
	);

	// Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1.
	function automatic logic [15:0] lfsr_next(input logic [15:0] state);
		lfsr_next = state >> 1;
		if (state[0])
			lfsr_next = lfsr_next ^ 16'hb400;
	endfunction

	task automatic take_random_bit(output logic value);
		value = lfsr[0];
		lfsr  = lfsr_next(lfsr);
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input msgq_pkg::word_t expected,
			input msgq_pkg::word_t actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL at %0d ns: %s expected %h, got %h",
				$time, name, expected, actual));
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("FAIL at %0d ns: %s expected %b, got %b",
				$time, name, expected, actual));
	endtask

	// Inputs change 1 ns after the edge, outputs are read at the same point.
	task automatic tick();
		@(posedge clk);
		#1;
	endtask

	task automatic bus_write(input logic [15:0] addr, input msgq_pkg::word_t data);
		bus_req.wr    = 1'b1;
		bus_req.addr  = addr;
		bus_req.wdata = data;
		tick();
		bus_req = '0;
	endtask

	task automatic bus_read_check(input logic [15:0] addr, input msgq_pkg::word_t expected);
		bus_req.rd   = 1'b1;
		bus_req.addr = addr;
		tick();
		check_bit("bus_rsp.rd_valid", 1'b1, bus_rsp.rd_valid);
		check_word($sformatf("bus_rsp.rdata at %h", addr), expected, bus_rsp.rdata);
		bus_req = '0;
	endtask

	// Words count up from the first one.
	task automatic push_words(input int count, input msgq_pkg::word_t first);
		logic accepted;
		for (int i = 0; i < count; i++) begin
			in_valid = 1'b1;
			in_data  = first + i;
			do begin
				accepted = in_ready;
				tick();
			end while (!accepted);
		end
		in_valid = 1'b0;
	endtask

	task automatic pop_words(input int count, input msgq_pkg::word_t first);
		logic            ready;
		logic            valid;
		msgq_pkg::word_t data;
		for (int i = 0; i < count; i++) begin
			do begin
				valid = out_valid;
				data  = out_data;
				take_random_bit(ready);
				out_ready = ready;
				tick();
			end while (!(valid && ready));
			check_word("out_data", first + i, data);
		end
		out_ready = 1'b0;
	endtask

	task automatic run_case(input int line, input logic [51:0] entry);
		logic [3:0]      op;
		logic [15:0]     arg;
		msgq_pkg::word_t data;
		op   = entry[51:48];
		arg  = entry[47:32];
		data = entry[31:0];
		case (op)
			4'h1: push_words(arg, data);
			4'h2: bus_write(arg, data);
			4'h3: bus_read_check(arg, data);
			4'h4: pop_words(arg, data);
			4'h5: check_bit("in_ready", data[0], in_ready);
			4'h6: begin
				// irq is registered from status.
				tick();
				check_bit("irq", data[0], irq);
			end
			default: abort_run($sformatf("Case %0d has an unknown command %h.", line, op));
		endcase
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= limit)
			abort_run($sformatf("The run did not finish within %0d cycles.", limit));
	end

	initial begin
		arst_n    = 1'b0;
		bus_req   = '0;
		in_valid  = 1'b0;
		in_data   = '0;
		out_ready = 1'b0;
		lfsr      = 16'd40;
		for (int i = 0; i < MAX_CASES; i++)
			cases[i] = '0;
		$readmemh("test/msgq_cases.txt", cases);
		case_count = 0;
		while (case_count < MAX_CASES && cases[case_count][51:48] != 4'h0)
			case_count++;
		if (case_count == 0)
			abort_run("No cases were loaded from test/msgq_cases.txt.");
		limit = 40 * case_count + 100;

		repeat (8) @(posedge clk);
		#1;
		arst_n = 1'b1;
		check_bit("in_ready", 1'b1, in_ready);
		check_bit("out_valid", 1'b0, out_valid);
		check_bit("bus_rsp.rd_valid", 1'b0, bus_rsp.rd_valid);
		check_bit("irq", 1'b0, irq);

		for (int i = 0; i < case_count; i++)
			run_case(i, cases[i]);

		// Every outbound word was popped, so a leftover one is a duplicate.
		tick();
		if (out_valid) begin
			abort_run("The outbound stream still offered a word after the last case.");
		end else begin
			$display("Finished with no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* sources.f */
logic/msgq_pkg.sv
logic/msgq_ring_ram.sv
logic/msgq_bus_port.sv
logic/msgq_regs.sv
logic/msgq_stream_in.sv
logic/msgq_stream_out.sv
logic/msgq_top.sv
test/msgq_clock.sv
test/msgq_tb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module msgq_tb -f sources.f -o msgq_sim

# A failing run ends in $fatal, so the log decides the result.
./obj_dir/msgq_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Finished with no errors" sim.log; then
	exit 0
else
	exit 1
fi

/* test/msgq_cases.txt */
// op_arg_data in hex. op 1 push arg words from data up, 2 bus write, 3 bus read and expect,
// op 4 pop arg words from data up, 5 expect in_ready, 6 expect irq; op 0 ends the list.
3_0000_00000000
3_0001_00000000
3_0002_00000000
3_0003_00000000
3_0004_00000000
3_0005_00000002
5_0000_00000001
6_0000_00000000
2_0004_00000001
6_0000_00000000
1_0003_a0000001
6_0000_00000001
3_0400_a0000001
3_0402_a0000003
3_0001_00000003
3_0005_00000003
2_0400_ffffffff
3_0400_a0000001
1_000c_a0000004
5_0000_00000000
3_0001_0000000f
3_040e_a000000f
2_0000_00000004
5_0000_00000001
1_0004_b0000001
5_0000_00000000
3_040f_b0000001
3_0402_b0000004
3_0001_00000003
2_0004_00000003
2_0000_00000003
6_0000_00000001
3_0005_00000002
2_0410_c0000001
2_0411_c0000002
2_0412_c0000003
2_0413_c0000004
2_0003_00000004
6_0000_00000000
3_0005_00000000
4_0004_c0000001
3_0002_00000004
3_0005_00000002
6_0000_00000001
